// File: verilog/ntm_gate_defines.svh
// Widths, size limits and sigmoid breakpoints of the NTM input gate
// Included by the package and by every RTL file that sizes a port

`ifndef NTM_GATE_DEFINES_SVH
`define NTM_GATE_DEFINES_SVH

//////////////////////////////
// Number format
//////////////////////////////

`define NTM_DATA_W 16  // Q8.8 datum
`define NTM_FRAC_W 8   // Fraction bits
`define NTM_ACC_W  32  // Accumulator

// Size inputs, up to 15 pairs per term
`define NTM_SIZE_W 4

//////////////////////////////
// Sigmoid breakpoints, Q8.8
//////////////////////////////

`define NTM_SIG_B1 16'h0100  // 1.0
`define NTM_SIG_B2 16'h0260  // 2.375
`define NTM_SIG_B3 16'h0500  // 5.0

`endif

// File: verilog/ntm_gate_pkg.sv
// Types shared by the input gate pipeline stages
// Decode emits gate_op_t, execute emits gate_acc_t

`include "ntm_gate_defines.svh"

package ntm_gate_pkg;

  //////////////////////////////
  // Term of an operand pair
  //////////////////////////////

  typedef enum logic [1:0] {
    TERM_W,  // Input weights times x
    TERM_K,  // Read weights times r
    TERM_U,  // Recurrent weights times h
    TERM_B   // Bias, closes an element
  } term_e;

  //////////////////////////////
  // Pipeline words
  //////////////////////////////

  // Decode to execute
  typedef struct packed {
    logic                   valid;
    term_e                  term;
    logic [`NTM_DATA_W-1:0] operand_a;   // Weight or bias
    logic [`NTM_DATA_W-1:0] operand_b;   // Activation, zero for bias
    logic                   last;        // Bias op of an element
    logic                   final_elem;  // Closing op of the last element
  } gate_op_t;

  // Execute to result
  typedef struct packed {
    logic                  valid;
    logic                  final_elem;  // Sum of the last element
    logic [`NTM_ACC_W-1:0] sum;         // Full accumulator at element close
  } gate_acc_t;

endpackage

// File: verilog/ntm_gate_decode.sv
// Term sequencer of the input gate
// Latches sizes on START, accepts only the strobe of the expected term
// and registers the selected pair as one op per accepted strobe

`timescale 1ns/10ps
`include "ntm_gate_defines.svh"

module ntm_gate_decode (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   START,
  input  logic [`NTM_SIZE_W-1:0] size_x,
  input  logic [`NTM_SIZE_W-1:0] size_r,
  input  logic [`NTM_SIZE_W-1:0] size_l,
  input  logic                   w_enable,
  input  logic                   k_enable,
  input  logic                   u_enable,
  input  logic                   b_enable,
  input  logic [`NTM_DATA_W-1:0] w_data,
  input  logic [`NTM_DATA_W-1:0] x_data,
  input  logic [`NTM_DATA_W-1:0] k_data,
  input  logic [`NTM_DATA_W-1:0] r_data,
  input  logic [`NTM_DATA_W-1:0] u_data,
  input  logic [`NTM_DATA_W-1:0] h_data,
  input  logic [`NTM_DATA_W-1:0] b_data,
  output ntm_gate_pkg::gate_op_t op,
  output logic                   order_error
);

  //////////////////////////////
  // State
  //////////////////////////////

  logic [`NTM_SIZE_W-1:0] size_x_q;   // Latched sizes
  logic [`NTM_SIZE_W-1:0] size_r_q;
  logic [`NTM_SIZE_W-1:0] size_l_q;
  logic                   busy;
  ntm_gate_pkg::term_e    term;       // Expected term
  logic [`NTM_SIZE_W-1:0] pair_cnt;   // Pairs seen in this term
  logic [`NTM_SIZE_W-1:0] elem_cnt;   // Elements closed so far

  logic                   exp_enable;
  logic                   any_enable;
  logic                   accept;
  logic                   wrong_term;
  logic [`NTM_SIZE_W-1:0] term_size;
  logic                   term_done;
  logic                   elem_done;
  logic [`NTM_DATA_W-1:0] sel_a;
  logic [`NTM_DATA_W-1:0] sel_b;

  // First term with a nonzero size, U always has size_l pairs
  function automatic ntm_gate_pkg::term_e first_term(input logic [`NTM_SIZE_W-1:0] sx,
                                                     input logic [`NTM_SIZE_W-1:0] sr);
    if (sx != '0) begin
      return ntm_gate_pkg::TERM_W;
    end else if (sr != '0) begin
      return ntm_gate_pkg::TERM_K;
    end
    return ntm_gate_pkg::TERM_U;
  endfunction

  //////////////////////////////
  // Strobe select
  //////////////////////////////

  always_comb begin
    case (term)
      ntm_gate_pkg::TERM_W: begin
        exp_enable = w_enable;
        term_size  = size_x_q;
        sel_a      = w_data;
        sel_b      = x_data;
      end
      ntm_gate_pkg::TERM_K: begin
        exp_enable = k_enable;
        term_size  = size_r_q;
        sel_a      = k_data;
        sel_b      = r_data;
      end
      ntm_gate_pkg::TERM_U: begin
        exp_enable = u_enable;
        term_size  = size_l_q;  // Recurrent pairs
        sel_a      = u_data;
        sel_b      = h_data;
      end
      default: begin          // Single bias word
        exp_enable = b_enable;
        term_size  = `NTM_SIZE_W'(1);
        sel_a      = b_data;
        sel_b      = '0;
      end
    endcase
  end

  assign any_enable = w_enable | k_enable | u_enable | b_enable;
  assign accept     = busy & exp_enable;
  assign wrong_term = busy & any_enable & ~exp_enable;  // Dropped strobe

  // Counts compared one bit wider, no wrap at 15
  assign term_done = ({1'b0, pair_cnt} + 1'b1) == {1'b0, term_size};
  assign elem_done = ({1'b0, elem_cnt} + 1'b1) == {1'b0, size_l_q};

  //////////////////////////////
  // Sequencer
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      size_x_q    <= '0;
      size_r_q    <= '0;
      size_l_q    <= '0;
      busy        <= 1'b0;
      term        <= ntm_gate_pkg::TERM_W;
      pair_cnt    <= '0;
      elem_cnt    <= '0;
      order_error <= 1'b0;
    end else if (!busy) begin
      if (START) begin
        size_x_q    <= size_x;
        size_r_q    <= size_r;
        size_l_q    <= size_l;
        busy        <= (size_l != '0);  // No elements, stay idle
        term        <= first_term(size_x, size_r);
        pair_cnt    <= '0;
        elem_cnt    <= '0;
        order_error <= 1'b0;
      end
    end else begin
      if (wrong_term) begin
        order_error <= 1'b1;  // Sticky until next START
      end
      if (accept) begin
        if (term == ntm_gate_pkg::TERM_B) begin
          if (elem_done) begin
            busy <= 1'b0;       // Last element closed
          end else begin
            elem_cnt <= elem_cnt + 1'b1;
            term     <= first_term(size_x_q, size_r_q);
          end
        end else if (term_done) begin
          pair_cnt <= '0;
          case (term)
            ntm_gate_pkg::TERM_W: begin
              if (size_r_q != '0) begin
                term <= ntm_gate_pkg::TERM_K;
              end else begin
                term <= ntm_gate_pkg::TERM_U;  // Skip empty K
              end
            end
            ntm_gate_pkg::TERM_K: term <= ntm_gate_pkg::TERM_U;
            default:              term <= ntm_gate_pkg::TERM_B;
          endcase
        end else begin
          pair_cnt <= pair_cnt + 1'b1;
        end
      end
    end
  end

  //////////////////////////////
  // Op register
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      op <= '0;
    end else begin
      op.valid <= accept;
      if (accept) begin
        op.term       <= term;
        op.operand_a  <= sel_a;
        op.operand_b  <= sel_b;
        op.last       <= (term == ntm_gate_pkg::TERM_B);
        op.final_elem <= (term == ntm_gate_pkg::TERM_B) && elem_done;
      end
    end
  end

endmodule

// File: verilog/ntm_gate_execute.sv
// Multiply-accumulate stage of the input gate
// Sums Q8.8 products of W, K and U ops, adds the bias and emits
// the element total one cycle after the closing op

`timescale 1ns/10ps
`include "ntm_gate_defines.svh"

module ntm_gate_execute (
  input  logic                    CLK,
  input  logic                    RST,
  input  ntm_gate_pkg::gate_op_t  op,
  output ntm_gate_pkg::gate_acc_t acc
);

  //////////////////////////////
  // Datapath
  //////////////////////////////

  logic signed [`NTM_ACC_W-1:0] product;   // Q16.16
  logic signed [`NTM_ACC_W-1:0] scaled;    // Back to Q8.8 scale
  logic signed [`NTM_ACC_W-1:0] bias_ext;
  logic signed [`NTM_ACC_W-1:0] addend;
  logic signed [`NTM_ACC_W-1:0] sum_q;     // Running sum of the element
  logic signed [`NTM_ACC_W-1:0] sum_next;

  // Operands sign-extended to 32 bits before the multiply
  assign product = $signed(op.operand_a) * $signed(op.operand_b);
  assign scaled  = product >>> `NTM_FRAC_W;

  assign bias_ext = {{(`NTM_ACC_W-`NTM_DATA_W){op.operand_a[`NTM_DATA_W-1]}}, op.operand_a};

  // Bias op carries no activation
  assign addend = (op.term == ntm_gate_pkg::TERM_B) ? bias_ext : scaled;

  // Wraps at 32 bits, out of reach for 15 pairs per term
  assign sum_next = sum_q + addend;

  //////////////////////////////
  // Accumulator
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      sum_q <= '0;
      acc   <= '0;
    end else begin
      acc.valid <= 1'b0;
      if (op.valid) begin
        if (op.last) begin
          acc.valid      <= 1'b1;       // Element closes
          acc.final_elem <= op.final_elem;
          acc.sum        <= sum_next;
          sum_q          <= '0;         // Next element from zero
        end else begin
          sum_q <= sum_next;
        end
      end
    end
  end

endmodule

// File: verilog/ntm_gate_logistic.sv
// Result stage of the input gate
// Saturates the element sum to Q8.8, applies the piecewise-linear
// sigmoid and strobes the value out one cycle after acc is valid

`timescale 1ns/10ps
`include "ntm_gate_defines.svh"

module ntm_gate_logistic (
  input  logic                    CLK,
  input  logic                    RST,
  input  ntm_gate_pkg::gate_acc_t acc,
  output logic [`NTM_DATA_W-1:0]  i_out,
  output logic                    i_out_enable,
  output logic                    ready
);

  //////////////////////////////
  // Saturate and fold
  //////////////////////////////

  logic [`NTM_DATA_W-1:0] sat;       // Clamped to signed 16 bits
  logic                   neg;
  logic [`NTM_DATA_W:0]   z;         // Magnitude, holds 32768
  logic [`NTM_DATA_W:0]   y;         // Sigmoid of |sum|, at most 1.0
  logic [`NTM_DATA_W-1:0] gate_val;

  always_comb begin
    if ($signed(acc.sum) > $signed(32'sd32767)) begin
      sat = 16'h7fff;
    end else if ($signed(acc.sum) < $signed(-32'sd32768)) begin
      sat = 16'h8000;
    end else begin
      sat = acc.sum[`NTM_DATA_W-1:0];
    end
  end

  assign neg = sat[`NTM_DATA_W-1];
  assign z   = neg ? (17'd0 - {1'b1, sat}) : {1'b0, sat};

  //////////////////////////////
  // PLAN segments
  //////////////////////////////

  // z is never negative, so shifts truncate toward zero
  always_comb begin
    if (z >= {1'b0, `NTM_SIG_B3}) begin
      y = 17'd256;                 // Flat at 1.0
    end else if (z >= {1'b0, `NTM_SIG_B2}) begin
      y = (z >> 5) + 17'd216;
    end else if (z >= {1'b0, `NTM_SIG_B1}) begin
      y = (z >> 3) + 17'd160;
    end else begin
      y = (z >> 2) + 17'd128;     // Around 0.5
    end
  end

  // Mirror for negative sums
  assign gate_val = neg ? (16'd256 - y[`NTM_DATA_W-1:0]) : y[`NTM_DATA_W-1:0];

  //////////////////////////////
  // Output registers
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      i_out_enable <= 1'b0;
      ready        <= 1'b0;
    end else begin
      i_out_enable <= acc.valid;
      ready        <= acc.valid & acc.final_elem;  // With last element only
    end
  end

  always_ff @(posedge CLK) begin
    if (acc.valid) begin
      i_out <= gate_val;
    end
  end

endmodule

// File: verilog/ntm_input_gate.sv
// Input gate of the NTM controller, i(l) = sigmoid(W.x + K.r + U.h + b(l))
// Host streams strobed pairs per element, I_OUT follows each bias by 3 cycles

`timescale 1ns/10ps
`include "ntm_gate_defines.svh"

module ntm_input_gate (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   START,
  input  logic [`NTM_SIZE_W-1:0] SIZE_X,
  input  logic [`NTM_SIZE_W-1:0] SIZE_R,
  input  logic [`NTM_SIZE_W-1:0] SIZE_L,
  input  logic                   W_IN_ENABLE,
  input  logic                   K_IN_ENABLE,
  input  logic                   U_IN_ENABLE,
  input  logic                   B_IN_ENABLE,
  input  logic [`NTM_DATA_W-1:0] W_IN,
  input  logic [`NTM_DATA_W-1:0] X_IN,
  input  logic [`NTM_DATA_W-1:0] K_IN,
  input  logic [`NTM_DATA_W-1:0] R_IN,
  input  logic [`NTM_DATA_W-1:0] U_IN,
  input  logic [`NTM_DATA_W-1:0] H_IN,
  input  logic [`NTM_DATA_W-1:0] B_IN,
  output logic [`NTM_DATA_W-1:0] I_OUT,
  output logic                   I_OUT_ENABLE,
  output logic                   READY,
  output logic                   ORDER_ERROR
);

  ntm_gate_pkg::gate_op_t  op;   // Decode to execute
  ntm_gate_pkg::gate_acc_t acc;  // Execute to result

  //////////////////////////////
  // Pipeline
  //////////////////////////////

  ntm_gate_decode decode0 (
    .CLK         (CLK),
    .RST         (RST),
    .START       (START),
    .size_x      (SIZE_X),
    .size_r      (SIZE_R),
    .size_l      (SIZE_L),
    .w_enable    (W_IN_ENABLE),
    .k_enable    (K_IN_ENABLE),
    .u_enable    (U_IN_ENABLE),
    .b_enable    (B_IN_ENABLE),
    .w_data      (W_IN),
    .x_data      (X_IN),
    .k_data      (K_IN),
    .r_data      (R_IN),
    .u_data      (U_IN),
    .h_data      (H_IN),
    .b_data      (B_IN),
    .op          (op),
    .order_error (ORDER_ERROR)
  );

  ntm_gate_execute execute0 (
    .CLK (CLK),
    .RST (RST),
    .op  (op),
    .acc (acc)
  );

  ntm_gate_logistic result0 (
    .CLK          (CLK),
    .RST          (RST),
    .acc          (acc),
    .i_out        (I_OUT),
    .i_out_enable (I_OUT_ENABLE),
    .ready        (READY)
  );

endmodule

// File: verification/ntm_gate_assertions.sv
// Concurrent checks on the input gate strobes
// Bound into every ntm_input_gate instance by the bind at the bottom

`timescale 1ns/10ps

module ntm_gate_assertions (
  input logic CLK,
  input logic RST,
  input logic W_IN_ENABLE,
  input logic K_IN_ENABLE,
  input logic U_IN_ENABLE,
  input logic B_IN_ENABLE,
  input logic I_OUT_ENABLE,
  input logic READY
);

  // Outputs stay quiet in reset
  reset_quiet: assert property (@(posedge CLK) RST |-> (!I_OUT_ENABLE && !READY))
    else $error("I_OUT_ENABLE or READY high while RST is high");

  // READY only with the last output
  ready_with_out: assert property (@(posedge CLK) disable iff (RST) READY |-> I_OUT_ENABLE)
    else $error("READY high without I_OUT_ENABLE");

  // Host drives one term per cycle
  one_enable: assert property (@(posedge CLK) disable iff (RST)
      $onehot0({W_IN_ENABLE, K_IN_ENABLE, U_IN_ENABLE, B_IN_ENABLE}))
    else $error("More than one input enable high in a cycle");

endmodule

bind ntm_input_gate ntm_gate_assertions assert0 (
  .CLK          (CLK),
  .RST          (RST),
  .W_IN_ENABLE  (W_IN_ENABLE),
  .K_IN_ENABLE  (K_IN_ENABLE),
  .U_IN_ENABLE  (U_IN_ENABLE),
  .B_IN_ENABLE  (B_IN_ENABLE),
  .I_OUT_ENABLE (I_OUT_ENABLE),
  .READY        (READY)
);

// File: verification/ntm_input_gate_tb.sv
// Testbench of the NTM input gate
// Streams random and directed elements, models the gate rules in a queue
// and checks every I_OUT for value, arrival cycle and READY

`timescale 1ns/10ps
`include "ntm_gate_defines.svh"

module ntm_input_gate_tb;

  localparam int T_W    = 0;  // Term codes of the host stream
  localparam int T_K    = 1;
  localparam int T_U    = 2;
  localparam int T_B    = 3;
  localparam int T_IDLE = 4;

  localparam int RANDOM_RUNS = 8;
  localparam int CYCLE_LIMIT = RANDOM_RUNS * 6 * (3 * 6 + 1) * 4  // Worst random sizes
                             + 14 * (1 + 14 + 1) * 4            // Region sweep
                             + 1 * (4 + 1) * 4                  // Order error run
                             + 200;

  typedef struct packed {
    logic [`NTM_DATA_W-1:0] value;
    logic                   fin;   // Last element of the run
    logic [31:0]            due;   // Cycle count at the output
  } expect_t;

  logic                   CLK;
  logic                   RST;
  logic                   START;
  logic [`NTM_SIZE_W-1:0] SIZE_X;
  logic [`NTM_SIZE_W-1:0] SIZE_R;
  logic [`NTM_SIZE_W-1:0] SIZE_L;
  logic                   W_IN_ENABLE;
  logic                   K_IN_ENABLE;
  logic                   U_IN_ENABLE;
  logic                   B_IN_ENABLE;
  logic [`NTM_DATA_W-1:0] W_IN;
  logic [`NTM_DATA_W-1:0] X_IN;
  logic [`NTM_DATA_W-1:0] K_IN;
  logic [`NTM_DATA_W-1:0] R_IN;
  logic [`NTM_DATA_W-1:0] U_IN;
  logic [`NTM_DATA_W-1:0] H_IN;
  logic [`NTM_DATA_W-1:0] B_IN;
  logic [`NTM_DATA_W-1:0] I_OUT;
  logic                   I_OUT_ENABLE;
  logic                   READY;
  logic                   ORDER_ERROR;

  int unsigned cycles = 0;
  int          seed;
  int          errors      = 0;
  int          out_count   = 0;
  int          ready_count = 0;
  int          model_acc   = 0;   // Running element sum
  int          last_cycle  = 0;   // Cycle count of the last strobe
  int          test_num    = 0;
  int          err_mark    = 0;
  int          out_mark    = 0;
  expect_t     exp_q[$];
  expect_t     head;

  ntm_input_gate dut0 (.*);

  //////////////////////////////
  // Clock, cycle count, timeout
  //////////////////////////////

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
  end

  always @(posedge CLK) begin
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, outputs still pending: %0d", cycles, exp_q.size());
      $display("RESULT: FAIL");
      $finish;
    end
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Q16.16 product back to Q8.8, floor
  function automatic int scaled_product(input logic [15:0] a, input logic [15:0] b);
    int p;
    p = int'($signed(a)) * int'($signed(b));
    return p >>> `NTM_FRAC_W;
  endfunction

  // Saturate, fold to magnitude, PLAN segments, mirror
  function automatic logic [15:0] gate_model(input int sum);
    int s;
    int z;
    int y;
    s = sum;
    if (s > 32767) begin
      s = 32767;
    end else if (s < -32768) begin
      s = -32768;
    end
    z = (s < 0) ? -s : s;
    if (z >= 1280) begin        // 5.0
      y = 256;
    end else if (z >= 608) begin  // 2.375
      y = z / 32 + 216;
    end else if (z >= 256) begin  // 1.0
      y = z / 8 + 160;
    end else begin
      y = z / 4 + 128;
    end
    if (s < 0) begin
      y = 256 - y;
    end
    return 16'(y);
  endfunction

  function automatic logic [15:0] rand_operand(input int span);
    return 16'($random(seed) % span);
  endfunction

  function automatic int rand_size();
    return 1 + int'($unsigned($random(seed)) % 6);  // 1 to 6
  endfunction

  //////////////////////////////
  // Output monitor
  //////////////////////////////

  always @(negedge CLK) begin
    if (RST) begin
      assert (!I_OUT_ENABLE && !READY && !ORDER_ERROR) else begin
        $display("Output strobe or ORDER_ERROR high during reset at %0t", $time);
        errors++;
      end
    end else begin
      assert (I_OUT_ENABLE || !READY) else begin
        $display("READY pulsed without I_OUT_ENABLE at %0t", $time);
        errors++;
      end
      if (I_OUT_ENABLE) begin
        out_count++;
        if (READY) begin
          ready_count++;
        end
        assert (exp_q.size() != 0) else begin
          $display("Output at %0t with no element pending", $time);
          errors++;
        end
        if (exp_q.size() != 0) begin
          head = exp_q.pop_front();
          assert (I_OUT == head.value) else begin
            $display("FAILED at %0t: I_OUT %h, expected %h", $time, I_OUT, head.value);
            errors++;
          end
          assert (cycles == head.due) else begin
            $display("FAILED at %0t: output at cycle %0d, expected %0d", $time, cycles,
                     head.due);
            errors++;
          end
          assert (READY == head.fin) else begin
            $display("FAILED at %0t: READY %b, expected %b", $time, READY, head.fin);
            errors++;
          end
        end
      end
    end
  end

  //////////////////////////////
  // Host stream tasks
  //////////////////////////////

  // One cycle of host drive, counted pairs go into the model
  task automatic send(input int term, input logic [15:0] a, input logic [15:0] b,
                      input bit counted);
    @(posedge CLK);
    START       <= 1'b0;
    W_IN_ENABLE <= 1'b0;
    K_IN_ENABLE <= 1'b0;
    U_IN_ENABLE <= 1'b0;
    B_IN_ENABLE <= 1'b0;
    case (term)
      T_W: begin
        W_IN_ENABLE <= 1'b1;
        W_IN        <= a;
        X_IN        <= b;
      end
      T_K: begin
        K_IN_ENABLE <= 1'b1;
        K_IN        <= a;
        R_IN        <= b;
      end
      T_U: begin
        U_IN_ENABLE <= 1'b1;
        U_IN        <= a;
        H_IN        <= b;
      end
      T_B: begin
        B_IN_ENABLE <= 1'b1;
        B_IN        <= a;
      end
      default: begin
      end
    endcase
    last_cycle = cycles + 1;  // Count steps on this edge, after this read
    if (counted) begin
      model_acc += scaled_product(a, b);
    end
  endtask

  task automatic send_bias(input logic [15:0] bias, input bit fin);
    expect_t e;
    send(T_B, bias, '0, 1'b0);
    model_acc += int'($signed(bias));
    e.value   = gate_model(model_acc);
    e.fin     = fin;
    e.due     = 32'(last_cycle + 3);  // Three stages after the strobe cycle
    exp_q.push_back(e);
    model_acc = 0;
  endtask

  task automatic idle_gap(input int gap_max);
    int n;
    n = int'($unsigned($random(seed)) % (gap_max + 1));
    repeat (n) send(T_IDLE, '0, '0, 1'b0);
  endtask

  task automatic start_run(input int sx, input int sr, input int sl);
    @(posedge CLK);
    START       <= 1'b1;
    SIZE_X      <= `NTM_SIZE_W'(sx);
    SIZE_R      <= `NTM_SIZE_W'(sr);
    SIZE_L      <= `NTM_SIZE_W'(sl);
    W_IN_ENABLE <= 1'b0;
    K_IN_ENABLE <= 1'b0;
    U_IN_ENABLE <= 1'b0;
    B_IN_ENABLE <= 1'b0;
    model_acc   = 0;
    ready_count = 0;
  endtask

  // Drain the pipeline, one READY per run
  task automatic finish_run();
    send(T_IDLE, '0, '0, 1'b0);
    while (exp_q.size() != 0) @(negedge CLK);
    repeat (2) @(negedge CLK);
    assert (ready_count == 1) else begin
      $display("FAILED at %0t: %0d READY pulses in the run, expected 1", $time, ready_count);
      errors++;
    end
  endtask

  task automatic run_elements(input int sx, input int sr, input int sl, input int gap_max);
    start_run(sx, sr, sl);
    for (int l = 0; l < sl; l++) begin
      for (int i = 0; i < sx; i++) begin
        send(T_W, rand_operand(512), rand_operand(512), 1'b1);
        idle_gap(gap_max);
      end
      for (int i = 0; i < sr; i++) begin
        send(T_K, rand_operand(512), rand_operand(512), 1'b1);
        idle_gap(gap_max);
      end
      for (int i = 0; i < sl; i++) begin
        send(T_U, rand_operand(512), rand_operand(512), 1'b1);
        idle_gap(gap_max);
      end
      send_bias(rand_operand(1024), l == sl - 1);
      idle_gap(gap_max);
    end
    finish_run();
  endtask

  // Biases at and between breakpoints, both signs, then overflowing products
  task automatic sweep_regions();
    logic [15:0] region [6];
    logic [15:0] bias;
    region = '{16'h0040, 16'h0100, 16'h0180, 16'h0260, 16'h0300, 16'h0500};
    start_run(1, 0, 14);
    for (int l = 0; l < 14; l++) begin
      if (l < 12) begin
        bias = (l % 2 == 1) ? (16'h0000 - region[l / 2]) : region[l / 2];
        send(T_W, '0, '0, 1'b1);
      end else begin
        bias = '0;
        send(T_W, (l == 12) ? 16'h7fff : 16'h8000, 16'h7fff, 1'b1);  // Far past 16 bits
      end
      for (int i = 0; i < 14; i++) begin
        send(T_U, '0, '0, 1'b1);
      end
      send_bias(bias, l == 13);
    end
    finish_run();
  endtask

  task automatic test_end(input string name);
    test_num++;
    $display("Test %0d, %s: %0d outputs, %0d errors", test_num, name,
             out_count - out_mark, errors - err_mark);
    out_mark = out_count;
    err_mark = errors;
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int snapshot;
    seed        = 32'h94146085;
    RST         = 1'b1;
    START       = 1'b0;
    SIZE_X      = '0;
    SIZE_R      = '0;
    SIZE_L      = '0;
    W_IN_ENABLE = 1'b0;
    K_IN_ENABLE = 1'b0;
    U_IN_ENABLE = 1'b0;
    B_IN_ENABLE = 1'b0;
    W_IN        = '0;
    X_IN        = '0;
    K_IN        = '0;
    R_IN        = '0;
    U_IN        = '0;
    H_IN        = '0;
    B_IN        = '0;
    repeat (16) @(posedge CLK);
    RST <= 1'b0;

    repeat (4) run_elements(rand_size(), rand_size(), rand_size(), 2);
    test_end("gate value with idle gaps");

    repeat (2) run_elements(rand_size(), rand_size(), rand_size(), 0);
    test_end("back-to-back elements");

    sweep_regions();
    test_end("sigmoid regions and saturation");

    run_elements(rand_size(), rand_size(), rand_size(), 0);
    snapshot = out_count;
    send(T_W, 16'h0100, 16'h0100, 1'b0);  // No START, must be ignored
    send(T_B, 16'h0100, '0, 1'b0);
    send(T_IDLE, '0, '0, 1'b0);
    repeat (6) @(negedge CLK);
    assert (out_count == snapshot && !ORDER_ERROR) else begin
      $display("Strobes while idle produced output or ORDER_ERROR at %0t", $time);
      errors++;
    end
    test_end("completion and idle strobes");

    start_run(2, 0, 1);
    send(T_W, rand_operand(512), rand_operand(512), 1'b1);
    send(T_K, rand_operand(512), rand_operand(512), 1'b0);  // Wrong term, dropped
    send(T_W, rand_operand(512), rand_operand(512), 1'b1);
    send(T_U, rand_operand(512), rand_operand(512), 1'b1);
    send_bias(rand_operand(1024), 1'b1);
    finish_run();
    assert (ORDER_ERROR) else begin
      $display("FAILED at %0t: ORDER_ERROR low after a wrong-term strobe", $time);
      errors++;
    end
    run_elements(3, 0, 2, 1);
    assert (!ORDER_ERROR) else begin
      $display("FAILED at %0t: ORDER_ERROR still high after START", $time);
      errors++;
    end
    test_end("order error and zero size");

    $display("Totals: %0d outputs checked, %0d errors", out_count, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: ntm_input_gate.f
+incdir+verilog
verilog/ntm_gate_pkg.sv
verilog/ntm_gate_decode.sv
verilog/ntm_gate_execute.sv
verilog/ntm_gate_logistic.sv
verilog/ntm_input_gate.sv
verification/ntm_gate_assertions.sv
verification/ntm_input_gate_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the input gate testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module ntm_input_gate_tb \
  -f ntm_input_gate.f \
  && ./obj_dir/Vntm_input_gate_tb | tee sim.log

grep -q "RESULT: PASS" sim.log \
  && echo "Simulation passed" \
  && exit 0 \
  || { echo "Simulation failed"; exit 1; }
